// ==== source/kbc_pkg.sv ====
// Keyboard controller shared definitions
package kbc_pkg;

    localparam int DATA_W  = 8;  // width of one received byte.
    localparam int FIFO_AW = 4;  // log2 of the fifo depth, giving 16 bytes per channel.
    localparam int DROP_W  = 8;  // width of the saturating drop counter.
    localparam int ADDR_W  = 4;  // width of the apb address bus.
    localparam int WORD_W  = 32; // width of the apb data buses.

    // bit positions of the fields held in the CTRL register.
    localparam int CTRL_KBD_EN  = 0;
    localparam int CTRL_AUX_EN  = 1;
    localparam int CTRL_KBD_IE  = 2;
    localparam int CTRL_AUX_IE  = 3;
    localparam int CTRL_KBD_CLR = 8;
    localparam int CTRL_AUX_CLR = 9;

    // source of a byte returned through DATA.
    typedef enum logic {
        CH_KBD = 1'b0,
        CH_AUX = 1'b1
    } chan_id_e;

    // register offsets on the apb bus.
    typedef enum logic [ADDR_W-1:0] {
        REG_DATA   = 4'h0,
        REG_STATUS = 4'h4,
        REG_CTRL   = 4'h8,
        REG_DROP   = 4'hC
    } reg_addr_e;

    // one deserialized byte from a device, qualified by a strobe.
    typedef struct packed {
        logic              valid; // high for one cycle per byte.
        logic [DATA_W-1:0] data;  // the received byte.
    } rx_byte_t;

    // controls driven from the register block into one channel.
    typedef struct packed {
        logic enable; // channel accepts bytes while high.
        logic clear;  // one cycle pulse that flushes the channel.
        logic pop;    // removes the head byte at the clock edge.
    } chan_ctrl_t;

    // state reported by one channel back to the register block.
    typedef struct packed {
        logic              empty;      // no byte is waiting.
        logic              full;       // all fifo entries are in use.
        logic [FIFO_AW:0]  level;      // number of bytes waiting, full flag on top.
        logic              overflow;   // sticky flag set by any dropped byte.
        logic [DROP_W-1:0] drop_count; // saturating count of dropped bytes.
        logic [DATA_W-1:0] head;       // byte at the fifo output.
    } chan_status_t;

endpackage

// ==== source/simple_fifo.sv ====
// Show-ahead FIFO
`timescale 1ns/1ps

module simple_fifo #(
    parameter int width  = 8, // width of one entry.
    parameter int widthu = 4  // log2 of the number of entries.
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sclr,   // synchronous flush of all entries.
    input  logic              rdreq,  // advance the head at the clock edge.
    input  logic              wrreq,  // store data at the clock edge.
    input  logic [width-1:0]  data,
    output logic              empty,
    output logic              full,
    output logic [width-1:0]  q,      // head entry, valid while not empty.
    output logic [widthu-1:0] usedw   // fill count, wraps to zero when full.
);

    logic [width-1:0]  mem [2**widthu]; // storage for the entries.
    logic [widthu-1:0] rd_ptr;          // index of the head entry.
    logic [widthu-1:0] wr_ptr;          // index of the next free entry.
    logic              rd_go;           // a read that really removes an entry.
    logic              wr_go;           // a write that really stores an entry.

    assign rd_go = rdreq && !empty;           // a read on an empty fifo is ignored.
    assign wr_go = wrreq && (!full || rdreq); // a full fifo takes a write only with a read.

    assign q     = mem[rd_ptr];               // show-ahead output straight from the array.
    assign empty = (usedw == '0) && !full;    // zero count means empty unless full is set.

    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[wr_ptr] <= data; // payload written into the free slot.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else if (sclr) begin
            rd_ptr <= '0; // flush returns both pointers to the first slot.
            wr_ptr <= '0;
        end else begin
            if (rd_go) rd_ptr <= rd_ptr + 1'b1; // pointers wrap around naturally.
            if (wr_go) wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            usedw <= '0;
            full  <= 1'b0;
        end else if (sclr) begin
            usedw <= '0;
            full  <= 1'b0;
        end else if (wr_go && !rd_go) begin
            usedw <= usedw + 1'b1;                      // wraps to zero on the last free slot.
            if (usedw == {widthu{1'b1}}) full <= 1'b1;  // the wrap is remembered here.
        end else if (rd_go && !wr_go) begin
            usedw <= usedw - 1'b1;                      // leaving full gives all ones.
            full  <= 1'b0;
        end
    end

    // a flush always leaves the fifo empty at the next cycle, whatever was requested.
    a_sclr_empties: assert property (@(posedge clk) disable iff (!rst_n)
        sclr |=> (usedw == '0) && !full);

endmodule

// ==== source/byte_channel.sv ====
// Byte receive channel
`timescale 1ns/1ps

module byte_channel import kbc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  rx_byte_t     rx,     // incoming byte strobe from the device.
    input  chan_ctrl_t   ctrl,   // enable, clear and pop from the register block.
    output chan_status_t status  // state reported to the register block.
);

    logic                fifo_empty;
    logic                fifo_full;
    logic [DATA_W-1:0]   fifo_q;
    logic [FIFO_AW-1:0]  fifo_usedw;
    logic                accept;     // byte goes into the fifo this cycle.
    logic                drop;       // byte is lost because the fifo has no room.
    logic                overflow;   // sticky record of any drop since the last clear.
    logic [DROP_W-1:0]   drop_count; // number of drops, stops at its maximum.

    // a clear wins over a byte arriving in the same cycle, so it blocks both outcomes.
    // a full fifo still has room when the head is popped at the same edge.
    assign accept = rx.valid && ctrl.enable && !ctrl.clear && (!fifo_full || ctrl.pop);
    assign drop   = rx.valid && ctrl.enable && !ctrl.clear && !accept;

    simple_fifo #(
        .width  (DATA_W),
        .widthu (FIFO_AW)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .sclr  (ctrl.clear),
        .rdreq (ctrl.pop),
        .wrreq (accept),
        .data  (rx.data),
        .empty (fifo_empty),
        .full  (fifo_full),
        .q     (fifo_q),
        .usedw (fifo_usedw)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow   <= 1'b0;
            drop_count <= '0;
        end else if (ctrl.clear) begin
            overflow   <= 1'b0; // clear wipes the error history together with the data.
            drop_count <= '0;
        end else if (drop) begin
            overflow <= 1'b1;
            if (drop_count != {DROP_W{1'b1}}) begin
                drop_count <= drop_count + 1'b1; // saturate instead of wrapping.
            end
        end
    end

    always_comb begin
        status            = '0;
        status.empty      = fifo_empty;
        status.full       = fifo_full;
        status.level      = {fifo_full, fifo_usedw}; // full flag restores the top bit.
        status.overflow   = overflow;
        status.drop_count = drop_count;
        status.head       = fifo_q;
    end

    // a byte taken while full rides on a pop, so the fifo must still be full afterwards.
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && fifo_full) |=> fifo_full);

    // the drop count only moves upward between clears.
    a_drop_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl.clear |=> (drop_count >= $past(drop_count)));

endmodule

// ==== source/host_regs.sv ====
// APB register block
`timescale 1ns/1ps

module host_regs import kbc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [WORD_W-1:0] pwdata,
    output logic [WORD_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  chan_status_t      kbd_status,
    input  chan_status_t      aux_status,
    output chan_ctrl_t        kbd_ctrl,
    output chan_ctrl_t        aux_ctrl,
    output logic              irq
);

    logic       access;    // second cycle of an apb transfer, where it completes.
    logic       addr_hit;  // offset matches one of the defined registers.
    logic       wr_ok;     // write to the only writable register.
    logic       rd_data;   // read of DATA that pops a byte.
    logic       data_vld;  // at least one channel holds a byte.
    chan_id_e   data_src;  // channel chosen to answer a DATA read.
    logic [3:0] ctrl_q;    // interrupt enables and channel enables.
    logic [DATA_W-1:0] data_byte; // head byte of the chosen channel.

    assign pready = 1'b1;              // the block never inserts wait states.
    assign access = psel && penable;

    always_comb begin
        case (paddr)
            REG_DATA, REG_STATUS, REG_CTRL, REG_DROP: addr_hit = 1'b1;
            default:                                  addr_hit = 1'b0;
        endcase
    end

    // only CTRL takes writes. any other write or unknown offset is an error.
    assign pslverr = access && (!addr_hit || (pwrite && paddr != REG_CTRL));
    assign wr_ok   = access && pwrite && paddr == REG_CTRL;
    assign rd_data = access && !pwrite && paddr == REG_DATA;

    // the keyboard channel always has priority over the auxiliary one.
    assign data_vld  = !kbd_status.empty || !aux_status.empty;
    assign data_src  = kbd_status.empty ? CH_AUX : CH_KBD;
    assign data_byte = (data_src == CH_KBD) ? kbd_status.head : aux_status.head;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0; // channels and interrupts start disabled.
        end else if (wr_ok) begin
            ctrl_q <= pwdata[3:0];
        end
    end

    always_comb begin
        kbd_ctrl        = '0;
        kbd_ctrl.enable = ctrl_q[CTRL_KBD_EN];
        kbd_ctrl.clear  = wr_ok && pwdata[CTRL_KBD_CLR]; // lasts only for the access cycle.
        kbd_ctrl.pop    = rd_data && data_vld && data_src == CH_KBD;
        aux_ctrl        = '0;
        aux_ctrl.enable = ctrl_q[CTRL_AUX_EN];
        aux_ctrl.clear  = wr_ok && pwdata[CTRL_AUX_CLR];
        aux_ctrl.pop    = rd_data && data_vld && data_src == CH_AUX;
    end

    always_comb begin
        prdata = '0; // unused bits and idle cycles read as zero.
        if (psel && !pwrite) begin
            case (paddr)
                REG_DATA: begin
                    if (data_vld) begin
                        prdata[DATA_W-1:0] = data_byte;
                        prdata[8]          = data_src;
                        prdata[9]          = 1'b1; // marks the byte as real data.
                    end
                end
                REG_STATUS: begin
                    prdata[4:0]  = kbd_status.level;
                    prdata[5]    = kbd_status.full;
                    prdata[6]    = kbd_status.overflow;
                    prdata[12:8] = aux_status.level;
                    prdata[13]   = aux_status.full;
                    prdata[14]   = aux_status.overflow;
                end
                REG_CTRL: begin
                    prdata[3:0] = ctrl_q; // clear bits are pulses and read as zero.
                end
                REG_DROP: begin
                    prdata[7:0]  = kbd_status.drop_count;
                    prdata[15:8] = aux_status.drop_count;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

    // a level interrupt for any enabled channel that still holds data.
    assign irq = (!kbd_status.empty && ctrl_q[CTRL_KBD_IE]) ||
                 (!aux_status.empty && ctrl_q[CTRL_AUX_IE]);

    // one DATA read removes at most one byte from one channel.
    a_single_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(kbd_ctrl.pop && aux_ctrl.pop));

    // an erroneous transfer leaves the control register as it was.
    a_err_no_effect: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |=> (ctrl_q == $past(ctrl_q)));

endmodule

// ==== source/kbc_top.sv ====
// Keyboard controller top level
`timescale 1ns/1ps

module kbc_top import kbc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [WORD_W-1:0] pwdata,
    output logic [WORD_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  rx_byte_t          kbd_rx,  // bytes from the keyboard deserializer.
    input  rx_byte_t          aux_rx,  // bytes from the mouse deserializer.
    output logic              irq
);

    chan_ctrl_t   kbd_ctrl;   // register block to keyboard channel.
    chan_ctrl_t   aux_ctrl;   // register block to auxiliary channel.
    chan_status_t kbd_status; // keyboard channel to register block.
    chan_status_t aux_status; // auxiliary channel to register block.

    byte_channel u_kbd (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (kbd_rx),
        .ctrl   (kbd_ctrl),
        .status (kbd_status)
    );

    byte_channel u_aux (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (aux_rx),
        .ctrl   (aux_ctrl),
        .status (aux_status)
    );

    // both channels meet here, where the host sees them as one device.
    host_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .kbd_status (kbd_status),
        .aux_status (aux_status),
        .kbd_ctrl   (kbd_ctrl),
        .aux_ctrl   (aux_ctrl),
        .irq        (irq)
    );

endmodule

// ==== verification/kbc_tb.sv ====
// Keyboard controller testbench
`timescale 1ns/1ps

module kbc_tb import kbc_pkg::*; ();

    localparam int HALF       = 50;           // half of the 100 ns clock period.
    localparam int MAX_CYCLES = 4000;         // ample margin over the length of all tests.
    localparam int DEPTH      = 1 << FIFO_AW; // bytes one channel can hold.

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [WORD_W-1:0] pwdata;
    logic [WORD_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    rx_byte_t          kbd_rx;
    rx_byte_t          aux_rx;
    logic              irq;

    int                errors;
    int                cycles = 0;
    logic [31:0]       seed;                  // xorshift state.
    logic [DATA_W-1:0] kbd_q [$];             // bytes the keyboard channel should hold.
    logic [DATA_W-1:0] aux_q [$];             // bytes the aux channel should hold.
    logic [1:0]        en_model;              // channel enables as last written.
    logic [1:0]        ovf_model;             // expected sticky overflow per channel.
    logic [DROP_W-1:0] drop_model [2];        // expected drop count per channel.

    kbc_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .kbd_rx  (kbd_rx),
        .aux_rx  (aux_rx),
        .irq     (irq)
    );

    always #HALF clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_byte(output logic [DATA_W-1:0] b);
        seed = xorshift32(seed);
        b    = seed[DATA_W-1:0]; // low bits of the new state.
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input chan_status_t exp,
                                input chan_status_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            errors++;
            exp_s = $sformatf("level %0d full %b ovf %b drops %0d",
                              exp.level, exp.full, exp.overflow, exp.drop_count);
            act_s = $sformatf("level %0d full %b ovf %b drops %0d",
                              act.level, act.full, act.overflow, act.drop_count);
            $display("[FAIL] %0t %s expected %s actual %s", $time, name, exp_s, act_s);
        end
    endtask

    // one APB transfer, sampled in the middle of the access cycle.
    task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [WORD_W-1:0] wdata,
                                output logic [WORD_W-1:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1; // setup cycle.
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1; // access cycle, it ends at the next rising edge.
        #(HALF / 2);
        rdata = prdata;
        err   = pslverr;
        check_bit("pready", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                             output logic err);
        logic [WORD_W-1:0] unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] rdata,
                            output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // the model keeps the bytes a channel must store or drop.
    task automatic send_byte(input chan_id_e ch, input logic [DATA_W-1:0] b);
        @(negedge clk);
        if (ch == CH_KBD) begin
            kbd_rx.valid = 1'b1;
            kbd_rx.data  = b;
        end else begin
            aux_rx.valid = 1'b1;
            aux_rx.data  = b;
        end
        if (en_model[ch]) begin
            if (ch == CH_KBD && kbd_q.size() < DEPTH) kbd_q.push_back(b);
            else if (ch == CH_AUX && aux_q.size() < DEPTH) aux_q.push_back(b);
            else begin
                ovf_model[ch] = 1'b1; // a full channel loses the byte.
                if (drop_model[ch] != {DROP_W{1'b1}}) drop_model[ch] = drop_model[ch] + 1'b1;
            end
        end
        @(negedge clk);
        kbd_rx.valid = 1'b0; // a strobe lasts one cycle.
        aux_rx.valid = 1'b0;
    endtask

    task automatic write_ctrl(input logic [WORD_W-1:0] value);
        logic e;
        apb_write(REG_CTRL, value, e);
        check_bit("pslverr", 1'b0, e);
        en_model = value[1:0];
        if (value[CTRL_KBD_CLR]) begin
            kbd_q.delete();
            ovf_model[0]  = 1'b0;
            drop_model[0] = '0;
        end
        if (value[CTRL_AUX_CLR]) begin
            aux_q.delete();
            ovf_model[1]  = 1'b0;
            drop_model[1] = '0;
        end
    endtask

    // keyboard bytes come first, an idle read gives zero.
    task automatic read_data_check();
        logic [WORD_W-1:0] exp;
        logic [WORD_W-1:0] r;
        logic              e;
        exp = '0;
        if (kbd_q.size() > 0) begin
            exp[9]   = 1'b1;
            exp[8]   = CH_KBD;
            exp[7:0] = kbd_q.pop_front();
        end else if (aux_q.size() > 0) begin
            exp[9]   = 1'b1;
            exp[8]   = CH_AUX;
            exp[7:0] = aux_q.pop_front();
        end
        apb_read(REG_DATA, r, e);
        check_word("DATA", exp, r);
        check_bit("pslverr", 1'b0, e);
    endtask

    function automatic chan_status_t model_status(input chan_id_e ch);
        chan_status_t st;
        int           n;
        st            = '0;
        n             = (ch == CH_KBD) ? kbd_q.size() : aux_q.size();
        st.level      = n;
        st.empty      = (n == 0);
        st.full       = (n == DEPTH);
        st.overflow   = ovf_model[ch];
        st.drop_count = drop_model[ch];
        return st;
    endfunction

    // rebuilds one channel's view from STATUS and DROP.
    task automatic read_status(input chan_id_e ch, output chan_status_t st);
        logic [WORD_W-1:0] s;
        logic [WORD_W-1:0] d;
        logic              e;
        apb_read(REG_STATUS, s, e);
        apb_read(REG_DROP, d, e);
        st = '0;
        if (ch == CH_KBD) begin
            st.level      = s[4:0];
            st.full       = s[5];
            st.overflow   = s[6];
            st.drop_count = d[7:0];
        end else begin
            st.level      = s[12:8];
            st.full       = s[13];
            st.overflow   = s[14];
            st.drop_count = d[15:8];
        end
        st.empty = (st.level == 0);
    endtask

    task automatic check_channel(input chan_id_e ch);
        chan_status_t act;
        read_status(ch, act);
        check_status((ch == CH_KBD) ? "kbd status" : "aux status", model_status(ch), act);
    endtask

    task automatic test_reset_state();
        logic [DATA_W-1:0] b;
        logic [WORD_W-1:0] r;
        logic              e;
        apb_read(REG_CTRL, r, e);
        check_word("CTRL", '0, r);
        apb_read(REG_STATUS, r, e);
        check_word("STATUS", '0, r);
        apb_read(REG_DROP, r, e);
        check_word("DROP", '0, r);
        read_data_check();
        check_bit("irq", 1'b0, irq);
        for (int i = 0; i < 3; i++) begin
            next_byte(b);
            send_byte(CH_KBD, b); // disabled channels ignore these.
            next_byte(b);
            send_byte(CH_AUX, b);
        end
        apb_read(REG_STATUS, r, e);
        check_word("STATUS", '0, r);
        apb_read(REG_DROP, r, e);
        check_word("DROP", '0, r);
        read_data_check();
    endtask

    task automatic test_fifo_order();
        logic [DATA_W-1:0] b;
        write_ctrl(32'h3);
        for (int i = 0; i < 10; i++) begin
            next_byte(b);
            send_byte(CH_AUX, b);
        end
        for (int i = 0; i < 10; i++) begin
            check_channel(CH_AUX); // level falls by one per read.
            read_data_check();
        end
        check_channel(CH_AUX);
    endtask

    task automatic test_priority();
        logic [DATA_W-1:0] b;
        for (int i = 0; i < 3; i++) begin
            next_byte(b);
            send_byte(CH_AUX, b);
            next_byte(b);
            send_byte(CH_KBD, b);
        end
        repeat (6) read_data_check();
        read_data_check(); // both empty by now.
    endtask

    task automatic test_overflow();
        logic [DATA_W-1:0] b;
        chan_status_t      exp;
        chan_status_t      act;
        for (int i = 0; i < DEPTH + 1; i++) begin
            next_byte(b);
            send_byte(CH_KBD, b);
        end
        exp            = '0;
        exp.full       = 1'b1;
        exp.level      = DEPTH;
        exp.overflow   = 1'b1;
        exp.drop_count = 1;
        read_status(CH_KBD, act);
        check_status("kbd status", exp, act);
        repeat (DEPTH) read_data_check();
        check_channel(CH_KBD);
    endtask

    task automatic test_clear_aux();
        logic [DATA_W-1:0] b;
        logic [WORD_W-1:0] r;
        logic              e;
        for (int i = 0; i < DEPTH + 2; i++) begin
            next_byte(b);
            send_byte(CH_AUX, b);
        end
        for (int i = 0; i < 2; i++) begin
            next_byte(b);
            send_byte(CH_KBD, b);
        end
        check_channel(CH_AUX);
        check_channel(CH_KBD);
        write_ctrl(32'h3 | (1 << CTRL_AUX_CLR));
        check_channel(CH_AUX);
        check_channel(CH_KBD); // keyboard keeps its bytes and its overflow.
        apb_read(REG_CTRL, r, e);
        check_word("CTRL", 32'h3, r);
        repeat (2) read_data_check();
        write_ctrl(32'h3 | (1 << CTRL_KBD_CLR));
        check_channel(CH_KBD);
    endtask

    task automatic test_irq_and_errors();
        logic [DATA_W-1:0] b;
        logic [WORD_W-1:0] r;
        logic              e;
        check_bit("irq", 1'b0, irq);
        next_byte(b);
        send_byte(CH_AUX, b);
        check_bit("irq", 1'b0, irq); // data waits but no interrupt is enabled.
        write_ctrl(32'h3 | (1 << CTRL_AUX_IE));
        check_bit("irq", 1'b1, irq);
        write_ctrl(32'h3 | (1 << CTRL_KBD_IE));
        check_bit("irq", 1'b0, irq);
        next_byte(b);
        send_byte(CH_KBD, b);
        check_bit("irq", 1'b1, irq);
        write_ctrl(32'hF);
        read_data_check();
        check_bit("irq", 1'b1, irq); // aux still holds its byte.
        read_data_check();
        check_bit("irq", 1'b0, irq);
        next_byte(b);
        send_byte(CH_KBD, b);
        apb_write(REG_STATUS, 32'hFFFF_FFFF, e);
        check_bit("pslverr", 1'b1, e);
        apb_write(4'h1, 32'h0, e);
        check_bit("pslverr", 1'b1, e);
        apb_read(4'h1, r, e);
        check_bit("pslverr", 1'b1, e);
        apb_read(REG_CTRL, r, e);
        check_word("CTRL", 32'hF, r);
        check_channel(CH_KBD);
        read_data_check();
        check_bit("irq", 1'b0, irq);
    endtask

    initial begin
        errors        = 0;
        seed          = 72366;
        clk           = 1'b0;
        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        kbd_rx        = '0;
        aux_rx        = '0;
        en_model      = '0;
        ovf_model     = '0;
        drop_model[0] = '0;
        drop_model[1] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_fifo_order();
        test_priority();
        test_overflow();
        test_clear_aux();
        test_irq_and_errors();
        $display("tests finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/kbc_pkg.sv
source/simple_fifo.sv
source/byte_channel.sv
source/host_regs.sv
source/kbc_top.sv
verification/kbc_tb.sv
